//--- jtcps1_gfx.f
+incdir+include
logic/gfx_layer_pkg.sv
logic/gfx_board_pkg.sv
logic/gfx_pipe_if.sv
logic/gfx_bank_select.sv
logic/gfx_mappers.sv
logic/gfx_rom_addr.sv
logic/gfx_mapper_top.sv
verif/gfx_mapper_tb.sv

//--- Makefile
# Verilator simulation of the graphics ROM address mapper
VERILATOR ?= verilator
TOP       ?= gfx_mapper_tb
FILELIST  ?= jtcps1_gfx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/gfx_mapper_tb.sv
// Testbench top with LCG stimulus, bank model, in-order scoreboard and latency check
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_mapper_tb;

    localparam int DRAIN_LIMIT = 16; // Idle cycles allowed for the pipe to empty

    logic                   clk;
    logic                   rst;
    logic [1:0]             board;
    logic [15:0]            bank_offset;
    logic [15:0]            bank_mask;
    logic                   req_valid;
    logic [2:0]             req_layer;
    logic [`GFX_CODE_W-1:0] req_code;
    logic [`GFX_ROW_W-1:0]  req_row;
    logic                   out_valid;
    logic                   rom_cs;
    logic [`GFX_ADDR_W-1:0] rom_addr;

    logic [31:0]            rng_state = 32'hcb47_154b;
    int                     cyc = 0;      // Counted on falling edges
    int                     n_checks = 0;
    int                     n_errors = 0;
    logic                   exp_cs[$];    // Expected results in request order
    logic [`GFX_ADDR_W-1:0] exp_addr[$];
    int                     exp_due[$];   // Cycle the result is owed

    gfx_mapper_top u_gfx_mapper_top (.*);

    always #2 clk = ~clk; // 4 ns period

    // LCG step
    // Upper bits are the good ones
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Bank that holds the tile on a given board
    // Returns -1 when no bank holds it
    function automatic int model_bank(input gfx_board_pkg::board_e brd,
                                      input gfx_layer_pkg::layer_e lyr,
                                      input logic [`GFX_CODE_W-1:0] code);
        int   bank;
        logic hi;
        hi   = code[`GFX_CODE_W-1];
        bank = 0; // Linear board
        case (brd)
            gfx_board_pkg::BRD_SPLIT: bank = (lyr == gfx_layer_pkg::LYR_STARS) ? 1 : int'(hi);
            gfx_board_pkg::BRD_QUAD: begin
                if (lyr == gfx_layer_pkg::LYR_SCR2)       bank = 2;
                else if (lyr == gfx_layer_pkg::LYR_SCR3)  bank = 3;
                else if (lyr == gfx_layer_pkg::LYR_STARS) bank = -1; // No star ROM
                else                                      bank = int'(code[`GFX_CODE_W-1 -: 2]);
            end
            gfx_board_pkg::BRD_DUAL: begin
                if (lyr == gfx_layer_pkg::LYR_SCR2 || lyr == gfx_layer_pkg::LYR_SCR3)
                    bank = 2 + int'(hi); // Second rule set
                else
                    bank = hi ? -1 : 0;
            end
            default: bank = 0;
        endcase
        return bank;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // One request on the next edge with its expected result queued
    task automatic send_req(input gfx_layer_pkg::layer_e lyr,
                            input logic [`GFX_CODE_W-1:0] code,
                            input logic [`GFX_ROW_W-1:0] row);
        int         bank;
        logic [3:0] field;
        @(posedge clk);
        req_valid <= 1'b1;
        req_layer <= lyr;
        req_code  <= code;
        req_row   <= row;
        bank  = model_bank(gfx_board_pkg::board_e'(board), lyr, code);
        field = 4'h0;
        if (bank >= 0) // Masked top code bits with the offset ORed on top
            field = (code[`GFX_CODE_W-1 -: 4] & 4'(bank_mask >> (4 * bank)))
                    | 4'(bank_offset >> (4 * bank));
        exp_cs.push_back(bank >= 0);
        exp_addr.push_back({field, code[5:0], row});
        exp_due.push_back(cyc + 3); // Fixed latency
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_cs.size() != 0 && waited < DRAIN_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (exp_cs.size() != 0) begin
            n_errors++;
            $display("timeout waiting for %0d results that never came out", exp_cs.size());
            exp_cs.delete();
            exp_addr.delete();
            exp_due.delete();
        end
    endtask

    // Board plus fresh random nibbles while the pipe is empty
    task automatic set_config(input gfx_board_pkg::board_e brd);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = next_rand();
        r2 = next_rand();
        @(posedge clk);
        board       <= brd;
        bank_offset <= r1[31:16];
        bank_mask   <= r2[31:16];
        req_valid   <= 1'b0;
    endtask

    task automatic run_random(input int n, input bit b2b);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < n; i++) begin
            r1 = next_rand();
            r2 = next_rand();
            send_req(gfx_layer_pkg::layer_e'(r1[31:29] % 3'd5), r2[31:22], r2[21:18]);
            if (!b2b)
                repeat (r1[25:24]) idle_cycle(); // Gap of 0 to 3
        end
    endtask

    // Every layer against every value of code bits 9:8
    task automatic sweep_layers();
        logic [31:0] r;
        for (int l = 0; l < 5; l++) begin
            for (int top = 0; top < 4; top++) begin
                r = next_rand();
                send_req(gfx_layer_pkg::layer_e'(3'(l)), {2'(top), r[31:24]}, r[23:20]);
            end
        end
    endtask

    task automatic run_board(input gfx_board_pkg::board_e brd);
        set_config(brd);
        sweep_layers();
        drain();
        run_random(60, 1'b0);
        drain();
    endtask

    task automatic pop_and_check();
        logic                   cs_e;
        logic [`GFX_ADDR_W-1:0] addr_e;
        int                     due;
        cs_e   = exp_cs.pop_front();
        addr_e = exp_addr.pop_front();
        due    = exp_due.pop_front();
        check_val("rom_cs", 32'(rom_cs), 32'(cs_e));
        if (rom_cs)
            check_val("rom_addr", 32'(rom_addr), 32'(addr_e)); // Don't care when deselected
        check_val("out_valid cycle", cyc, due);
    endtask

    // Output monitor on the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_cs.size() == 0) begin
                n_errors++;
                $display("result came out with no request outstanding at %0t ns", $time);
            end else begin
                pop_and_check();
            end
        end
        cyc = cyc + 1;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        board       = 2'd0;
        bank_offset = 16'h0;
        bank_mask   = 16'hffff;
        req_valid   = 1'b0;
        req_layer   = 3'd0;
        req_code    = '0;
        req_row     = '0;
        repeat (2) begin // Outputs quiet during reset
            @(negedge clk);
            check_val("out_valid", 32'(out_valid), 32'h0);
            check_val("rom_cs", 32'(rom_cs), 32'h0);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk); // First cycle out of reset
        check_val("out_valid", 32'(out_valid), 32'h0);
        check_val("rom_cs", 32'(rom_cs), 32'h0);
        run_board(gfx_board_pkg::BRD_LINEAR);
        run_board(gfx_board_pkg::BRD_SPLIT);
        run_board(gfx_board_pkg::BRD_QUAD);
        run_board(gfx_board_pkg::BRD_DUAL);
        for (int b = 0; b < 4; b++) begin // Full load with a request every cycle
            set_config(gfx_board_pkg::board_e'(2'(b)));
            run_random(80, 1'b1);
            drain();
        end
        repeat (8) begin
            set_config(gfx_board_pkg::board_e'(2'(next_rand() >> 30)));
            run_random(40, 1'b0);
            drain();
        end
        report_and_finish();
    end

endmodule

//--- logic/gfx_mapper_top.sv
// Module gfx_mapper_top, three-stage graphics ROM address mapper
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_mapper_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [1:0]              board,       // board_e encoding
    input  logic [15:0]             bank_offset, // Quasi-static
    input  logic [15:0]             bank_mask,   // Quasi-static
    input  logic                    req_valid,
    input  logic [2:0]              req_layer,   // layer_e encoding
    input  logic [`GFX_CODE_W-1:0]  req_code,
    input  logic [`GFX_ROW_W-1:0]   req_row,
    output logic                    out_valid,   // Three cycles after req_valid
    output logic                    rom_cs,
    output logic [`GFX_ADDR_W-1:0]  rom_addr
);

    gfx_bank_if  u_bank_if ();
    gfx_field_if u_field_if ();

    // Stage 1, bank choice
    gfx_bank_select u_bank_select (
        .clk       (clk),
        .rst       (rst),
        .board     (gfx_board_pkg::board_e'(board)),
        .req_valid (req_valid),
        .req_layer (gfx_layer_pkg::layer_e'(req_layer)),
        .req_code  (req_code),
        .req_row   (req_row),
        .bnk       (u_bank_if.src)
    );

    // Stage 2, offset and mask
    gfx_mappers u_mappers (
        .clk         (clk),
        .rst         (rst),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .bnk         (u_bank_if.dst),
        .fld         (u_field_if.src)
    );

    // Stage 3, address and chip select
    gfx_rom_addr u_rom_addr (
        .clk       (clk),
        .rst       (rst),
        .fld       (u_field_if.dst),
        .out_valid (out_valid),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr)
    );

endmodule

//--- logic/gfx_rom_addr.sv
// ROM address and chip select stage, last in the pipeline
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_rom_addr (
    input  logic                    clk,
    input  logic                    rst,
    gfx_field_if.dst                fld,
    output logic                    out_valid,
    output logic                    rom_cs,
    output logic [`GFX_ADDR_W-1:0]  rom_addr
);

    logic [3:0]              top_field;
    logic [`GFX_ADDR_W-1:0]  nxt_addr;

    // Upper code bits relocated into the bank window
    assign top_field = (fld.code[`GFX_CODE_W-1 -: 4] & fld.mask) | fld.offset;

    // Field, low six code bits, row
    assign nxt_addr = {top_field, fld.code[5:0], fld.row};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            rom_cs    <= 1'b0;
        end else begin
            out_valid <= fld.valid;
            rom_cs    <= fld.valid && !fld.unmapped; // Low for unmapped tiles
        end
    end

    // Address only matters while rom_cs is high
    always_ff @(posedge clk) begin
        rom_addr <= nxt_addr;
    end

    // Chip select is always part of a valid result
    a_cs_valid: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> out_valid);

endmodule

//--- logic/gfx_mappers.sv
// Module gfx_mappers, bank to offset and mask, second pipeline stage
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_mappers (
    input  logic         clk,
    input  logic         rst,
    input  logic [15:0]  bank_offset, // Nibble k for bank k
    input  logic [15:0]  bank_mask,   // Nibble k for bank k
    gfx_bank_if.dst      bnk,
    gfx_field_if.src     fld
);

    logic [`GFX_BANKS-1:0] eff_bank;
    logic [3:0]            nxt_offset;
    logic [3:0]            nxt_mask;

    // Second rule set overrides when flagged
    assign eff_bank = bnk.set_used ? bnk.bank_b : bnk.bank_a;

    always_comb begin
        case (eff_bank)
            4'b0001: begin
                nxt_offset = bank_offset[3:0];
                nxt_mask   = bank_mask[3:0];
            end
            4'b0010: begin
                nxt_offset = bank_offset[7:4];
                nxt_mask   = bank_mask[7:4];
            end
            4'b0100: begin
                nxt_offset = bank_offset[11:8];
                nxt_mask   = bank_mask[11:8];
            end
            4'b1000: begin
                nxt_offset = bank_offset[15:12];
                nxt_mask   = bank_mask[15:12];
            end
            default: begin
                nxt_offset = 4'h0; // Unmapped, code bits pass untouched
                nxt_mask   = 4'hf;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fld.valid    <= 1'b0;
            fld.unmapped <= 1'b1;
            fld.offset   <= 4'h0;
            fld.mask     <= 4'h0;
        end else begin
            fld.valid    <= bnk.valid;
            fld.unmapped <= eff_bank == '0; // No bank chosen
            fld.offset   <= nxt_offset;
            fld.mask     <= nxt_mask;
        end
    end

    always_ff @(posedge clk) begin
        fld.code <= bnk.code;
        fld.row  <= bnk.row;
    end

    a_eff_oh: assert property (@(posedge clk) disable iff (rst)
        bnk.valid |-> $onehot0(eff_bank));

endmodule

//--- logic/gfx_bank_select.sv
// Module gfx_bank_select, per-board bank rules, first pipeline stage
`timescale 1ns/1ps
`include "gfx_config.svh"

module gfx_bank_select (
    input  logic                    clk,
    input  logic                    rst,
    input  gfx_board_pkg::board_e   board,
    input  logic                    req_valid,
    input  gfx_layer_pkg::layer_e   req_layer,
    input  logic [`GFX_CODE_W-1:0]  req_code,
    input  logic [`GFX_ROW_W-1:0]   req_row,
    gfx_bank_if.src                 bnk
);

    logic                   code9;  // Top code bit
    logic [1:0]             code98; // Top two code bits
    logic [`GFX_BANKS-1:0]  nxt_a;
    logic [`GFX_BANKS-1:0]  nxt_b;
    logic                   nxt_set;

    assign code9  = req_code[`GFX_CODE_W-1];
    assign code98 = req_code[`GFX_CODE_W-1 -: 2];

    // Bank number to one-hot
    function automatic logic [`GFX_BANKS-1:0] bank_oh(input logic [1:0] idx);
        return `GFX_BANKS'(1) << idx;
    endfunction

    always_comb begin
        nxt_a   = '0; // Anything a rule leaves alone stays unmapped
        nxt_b   = '0;
        nxt_set = 1'b0;
        case (board)
            gfx_board_pkg::BRD_LINEAR: nxt_a = bank_oh(2'd0);
            gfx_board_pkg::BRD_SPLIT: begin
                if (req_layer == gfx_layer_pkg::LYR_STARS)
                    nxt_a = bank_oh(2'd1);
                else if (req_layer inside {gfx_layer_pkg::LYR_OBJ, gfx_layer_pkg::LYR_SCR1,
                                           gfx_layer_pkg::LYR_SCR2, gfx_layer_pkg::LYR_SCR3})
                    nxt_a = bank_oh({1'b0, code9});
            end
            gfx_board_pkg::BRD_QUAD: begin
                case (req_layer)
                    gfx_layer_pkg::LYR_OBJ,
                    gfx_layer_pkg::LYR_SCR1: nxt_a = bank_oh(code98);
                    gfx_layer_pkg::LYR_SCR2: nxt_a = bank_oh(2'd2);
                    gfx_layer_pkg::LYR_SCR3: nxt_a = bank_oh(2'd3);
                    default:                 nxt_a = '0; // No star ROM
                endcase
            end
            gfx_board_pkg::BRD_DUAL: begin
                if (req_layer == gfx_layer_pkg::LYR_SCR2 ||
                    req_layer == gfx_layer_pkg::LYR_SCR3) begin
                    nxt_set = 1'b1; // Second rule set
                    nxt_b   = bank_oh({1'b1, code9});
                end else if (!code9) begin
                    nxt_a = bank_oh(2'd0);
                end
            end
            default: nxt_a = '0;
        endcase
    end

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bnk.valid    <= 1'b0;
            bnk.bank_a   <= '0;
            bnk.bank_b   <= '0;
            bnk.set_used <= 1'b0;
        end else begin
            bnk.valid    <= req_valid;
            bnk.bank_a   <= nxt_a;
            bnk.bank_b   <= nxt_b;
            bnk.set_used <= nxt_set;
        end
    end

    // Payload travels alongside
    always_ff @(posedge clk) begin
        bnk.code <= req_code;
        bnk.row  <= req_row;
    end

    // Set B in use means set A carries nothing, both stay one-hot or zero
    a_bank_oh: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bnk.bank_a) && $onehot0(bnk.bank_b) &&
        (!bnk.set_used || bnk.bank_a == '0));

endmodule

//--- logic/gfx_pipe_if.sv
// Stage interfaces gfx_bank_if and gfx_field_if
`timescale 1ns/1ps
`include "gfx_config.svh"

// Bank selector to mapper stage
interface gfx_bank_if;
    logic                    valid;    // Request strobe
    logic [`GFX_CODE_W-1:0]  code;     // Tile code
    logic [`GFX_ROW_W-1:0]   row;      // Tile row
    logic [`GFX_BANKS-1:0]   bank_a;   // Default rule set, one-hot
    logic [`GFX_BANKS-1:0]   bank_b;   // Second rule set, one-hot
    logic                    set_used; // Take bank_b instead of bank_a

    modport src (
        output valid, code, row,
        output bank_a, bank_b, set_used
    );

    modport dst (
        input valid, code, row,
        input bank_a, bank_b, set_used
    );
endinterface

// Mapper stage to address composer
interface gfx_field_if;
    logic                    valid;
    logic [`GFX_CODE_W-1:0]  code;
    logic [`GFX_ROW_W-1:0]   row;
    logic [3:0]              offset;   // ORed into top field
    logic [3:0]              mask;     // ANDed with top code bits
    logic                    unmapped; // No bank held the tile

    modport src (
        output valid, code, row,
        output offset, mask, unmapped
    );

    modport dst (
        input valid, code, row,
        input offset, mask, unmapped
    );
endinterface

//--- logic/gfx_board_pkg.sv
// Board type enum for the cartridge ROM wiring
package gfx_board_pkg;

    // Each board routes the tile code to the ROM banks differently
    typedef enum logic [1:0] {
        BRD_LINEAR = 2'd0, // Single bank for everything
        BRD_SPLIT  = 2'd1, // Top code bit picks bank 0 or 1
        BRD_QUAD   = 2'd2, // Top two code bits, scroll planes fixed
        BRD_DUAL   = 2'd3  // Second rule set for SCR2 and SCR3
    } board_e;

    // BRD_LINEAR
    //   All layers in bank 0
    // BRD_SPLIT
    //   OBJ and scrolls split on code bit 9
    //   Star field in bank 1
    // BRD_QUAD
    //   OBJ and SCR1 use code bits 9:8 as bank number
    //   SCR2 in bank 2, SCR3 in bank 3
    //   No star field ROM
    // BRD_DUAL
    //   SCR2 and SCR3 go through set B, bank 2 or 3 by code bit 9
    //   Other layers only in bank 0, upper half of code unmapped

    // Board type is set once per game
    // Switching it with requests in flight gives undefined results

endpackage

//--- logic/gfx_layer_pkg.sv
// Layer enum for the tile fetch requests
package gfx_layer_pkg;

    // Encoding follows address bits 22 to 20 of the CPS1 board
    //   0  OBJ
    //   1  scroll 1
    //   2  scroll 2
    //   3  scroll 3
    //   4  star field
    // Codes 5 to 7 never come from a fetcher
    typedef enum logic [2:0] {
        LYR_OBJ   = 3'd0, // Sprites
        LYR_SCR1  = 3'd1, // 8x8 plane
        LYR_SCR2  = 3'd2, // 16x16 plane
        LYR_SCR3  = 3'd3, // 32x32 plane
        LYR_STARS = 3'd4  // Star field
    } layer_e;

    // Star field shares the ROM with the scroll planes on most boards
    // but some wirings leave it out entirely

    // Sprite and scroll fetchers issue one row per request
    // and the layer rides along with the code for bank selection

    // The mapper pipeline only needs the layer in its first stage
    // Later stages see the chosen bank instead

endpackage

//--- include/gfx_config.svh
// Width macros for the graphics ROM address mapper
`ifndef GFX_CONFIG_SVH
`define GFX_CONFIG_SVH

// Tile code from the fetcher
`define GFX_CODE_W 10

// Tile row within the tile
`define GFX_ROW_W 4

// ROM banks per board
// Also the width of every one-hot bank vector
`define GFX_BANKS 4

// Composed ROM address: 4-bit field, low six code bits, row
`define GFX_ADDR_W 14

`endif
